/* hdl/CpuPkg.sv */
package CpuPkg;

    // Datapath width
    localparam int Xlen = 32;

    // Register file size
    localparam int RegCount = 32;

    // Instruction memory, word indexed
    localparam int ImemAw    = 8;
    localparam int ImemWords = 1 << ImemAw;

    // Data memory, word indexed
    localparam int DmemAw    = 8;
    localparam int DmemWords = 1 << DmemAw;

    // addi x0, x0, 0
    localparam logic [Xlen-1:0] NopInst = 32'h0000_0013;

    // Major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        OpReg   = 7'b0110011,
        OpImm   = 7'b0010011,
        OpLoad  = 7'b0000011,
        OpStore = 7'b0100011
    } OpcodeT;

    // ALU operations, order follows funct3 with the alternate forms after
    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluSll  = 4'd2,
        AluSlt  = 4'd3,
        AluSltu = 4'd4,
        AluXor  = 4'd5,
        AluSrl  = 4'd6,
        AluSra  = 4'd7,
        AluOr   = 4'd8,
        AluAnd  = 4'd9
    } AluOpT;

endpackage

/* hdl/InstMem.sv */
`timescale 1ns/10ps

module InstMem import CpuPkg::*; (
    input  logic              CLK,
    input  logic              ProgWe,   // Boot load strobe
    input  logic [ImemAw-1:0] ProgAddr,
    input  logic [Xlen-1:0]   ProgData,
    input  logic [ImemAw-1:0] Addr,     // Fetch word index
    output logic [Xlen-1:0]   Inst
);

    logic [Xlen-1:0] mem [ImemWords];

    // Boot writes only, the core never stores here
    always_ff @(posedge CLK) begin
        if (ProgWe) begin
            mem[ProgAddr] <= ProgData;
        end
    end

    assign Inst = mem[Addr]; // Combinational fetch

endmodule

/* hdl/RegFile.sv */
`timescale 1ns/10ps

module RegFile import CpuPkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic [4:0]      Rr1,  // Read register 1
    input  logic [4:0]      Rr2,  // Read register 2
    input  logic [4:0]      Wr,   // Write register
    input  logic [Xlen-1:0] Wd,
    input  logic            We,
    output logic [Xlen-1:0] Rd1,
    output logic [Xlen-1:0] Rd2
);

    logic [Xlen-1:0] regs [RegCount];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (We && Wr != 5'd0) begin // x0 stays zero
            regs[Wr] <= Wd;
        end
    end

    // Reads see the old value during a write cycle
    assign Rd1 = (Rr1 == 5'd0) ? '0 : regs[Rr1];
    assign Rd2 = (Rr2 == 5'd0) ? '0 : regs[Rr2];

endmodule

/* hdl/DataMem.sv */
`timescale 1ns/10ps

module DataMem import CpuPkg::*; (
    input  logic              CLK,
    input  logic [DmemAw-1:0] Addr, // Word index
    input  logic              We,
    input  logic [Xlen-1:0]   Wd,
    output logic [Xlen-1:0]   Rd
);

    logic [Xlen-1:0] mem [DmemWords];

    // Whole word stores only
    always_ff @(posedge CLK) begin
        if (We) begin
            mem[Addr] <= Wd;
        end
    end

    assign Rd = mem[Addr];

endmodule

/* hdl/Alu.sv */
`timescale 1ns/10ps

module Alu import CpuPkg::*; (
    input  logic [Xlen-1:0] A,
    input  logic [Xlen-1:0] B,
    input  AluOpT           Op,
    output logic [Xlen-1:0] Y
);

    logic [4:0] shamt;

    assign shamt = B[4:0]; // RV32 shifts use five bits

    always_comb begin
        case (Op)
            AluAdd:  Y = A + B;
            AluSub:  Y = A - B;
            AluSll:  Y = A << shamt;
            AluSlt:  Y = ($signed(A) < $signed(B)) ? Xlen'(1) : '0;
            AluSltu: Y = (A < B) ? Xlen'(1) : '0;
            AluXor:  Y = A ^ B;
            AluSrl:  Y = A >> shamt;
            AluSra:  Y = $signed(A) >>> shamt; // Sign fill
            AluOr:   Y = A | B;
            AluAnd:  Y = A & B;
            default: Y = '0;
        endcase
    end

endmodule

/* hdl/Decoder.sv */
`timescale 1ns/10ps

module Decoder import CpuPkg::*; (
    input  logic [Xlen-1:0] Inst,
    output logic [4:0]      Rs1,
    output logic [4:0]      Rs2,
    output logic [4:0]      Rd,
    output logic [Xlen-1:0] Imm,
    output AluOpT           AluOp,
    output logic            UseImm,   // ALU operand B from Imm
    output logic            MemToReg, // Write back load data
    output logic            RegWrite,
    output logic            MemWrite
);

    OpcodeT          opcode;
    logic [2:0]      funct3;
    logic            altBit;
    logic [Xlen-1:0] immI;
    logic [Xlen-1:0] immS;

    // Map funct3 to an ALU operation
    // Bit 30 picks sra always, and sub only when the caller allows it
    function automatic AluOpT funct3ToOp(input logic [2:0] f3, input logic alt,
                                         input logic allowSub);
        AluOpT op;
        case (f3)
            3'b000:  op = (alt && allowSub) ? AluSub : AluAdd;
            3'b001:  op = AluSll;
            3'b010:  op = AluSlt;
            3'b011:  op = AluSltu;
            3'b100:  op = AluXor;
            3'b101:  op = alt ? AluSra : AluSrl;
            3'b110:  op = AluOr;
            default: op = AluAnd;
        endcase
        return op;
    endfunction

    assign opcode = OpcodeT'(Inst[6:0]);
    assign funct3 = Inst[14:12];
    assign altBit = Inst[30];

    assign Rs1 = Inst[19:15];
    assign Rs2 = Inst[24:20];
    assign Rd  = Inst[11:7];

    // Sign extended I and S immediates
    assign immI = {{(Xlen-12){Inst[31]}}, Inst[31:20]};
    assign immS = {{(Xlen-12){Inst[31]}}, Inst[31:25], Inst[11:7]};
    assign Imm  = (opcode == OpStore) ? immS : immI;

    always_comb begin
        AluOp    = AluAdd;
        UseImm   = 1'b0;
        MemToReg = 1'b0;
        RegWrite = 1'b0;
        MemWrite = 1'b0;
        case (opcode)
            OpReg: begin
                AluOp    = funct3ToOp(funct3, altBit, 1'b1);
                RegWrite = 1'b1;
            end
            OpImm: begin
                AluOp    = funct3ToOp(funct3, altBit, 1'b0); // No subi
                UseImm   = 1'b1;
                RegWrite = 1'b1;
            end
            OpLoad: begin
                UseImm   = 1'b1; // Address is rs1 + imm
                MemToReg = 1'b1;
                RegWrite = 1'b1;
            end
            OpStore: begin
                UseImm   = 1'b1;
                MemWrite = 1'b1;
            end
            default: ; // Unknown opcode retires as a no-op
        endcase
    end

endmodule

/* hdl/SingleCpu.sv */
`timescale 1ns/10ps

module SingleCpu import CpuPkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  logic              ProgWe,
    input  logic [ImemAw-1:0] ProgAddr,
    input  logic [Xlen-1:0]   ProgData,
    output logic [Xlen-1:0]   Pc,
    output logic [Xlen-1:0]   Inst,
    output logic              WbValid,
    output logic [4:0]        WbReg,
    output logic [Xlen-1:0]   WbData,
    output logic              StoreValid,
    output logic [Xlen-1:0]   StoreAddr,
    output logic [Xlen-1:0]   StoreData
);

    logic [4:0]      rs1Idx;
    logic [4:0]      rs2Idx;
    logic [4:0]      rdIdx;
    logic [Xlen-1:0] imm;
    AluOpT           aluOp;
    logic            useImm;
    logic            memToReg;
    logic            regWrite;
    logic            memWrite;
    logic [Xlen-1:0] rd1Data;
    logic [Xlen-1:0] rd2Data;
    logic [Xlen-1:0] aluB;
    logic [Xlen-1:0] aluY;
    logic [Xlen-1:0] memRdata;
    logic [Xlen-1:0] wbValue;

    // No branches, so the PC only steps
    always_ff @(posedge CLK) begin
        if (RST) begin
            Pc <= '0;
        end else begin
            Pc <= Pc + Xlen'(4);
        end
    end

    InstMem InstMem_inst (
        .CLK      (CLK),
        .ProgWe   (ProgWe),
        .ProgAddr (ProgAddr),
        .ProgData (ProgData),
        .Addr     (Pc[ImemAw+1:2]),
        .Inst     (Inst)
    );

    Decoder Decoder_inst (
        .Inst     (Inst),
        .Rs1      (rs1Idx),
        .Rs2      (rs2Idx),
        .Rd       (rdIdx),
        .Imm      (imm),
        .AluOp    (aluOp),
        .UseImm   (useImm),
        .MemToReg (memToReg),
        .RegWrite (regWrite),
        .MemWrite (memWrite)
    );

    RegFile RegFile_inst (
        .CLK (CLK),
        .RST (RST),
        .Rr1 (rs1Idx),
        .Rr2 (rs2Idx),
        .Wr  (rdIdx),
        .Wd  (wbValue),
        .We  (regWrite),
        .Rd1 (rd1Data),
        .Rd2 (rd2Data)
    );

    assign aluB = useImm ? imm : rd2Data;

    Alu Alu_inst (
        .A  (rd1Data),
        .B  (aluB),
        .Op (aluOp),
        .Y  (aluY)
    );

    // Effective address comes straight from the ALU sum
    DataMem DataMem_inst (
        .CLK  (CLK),
        .Addr (aluY[DmemAw+1:2]),
        .We   (StoreValid), // Keep memory safe while held in reset
        .Wd   (rd2Data),
        .Rd   (memRdata)
    );

    assign wbValue = memToReg ? memRdata : aluY;

    // Retire trace for the current instruction
    assign WbValid    = regWrite && (rdIdx != 5'd0) && !RST;
    assign WbReg      = rdIdx;
    assign WbData     = wbValue;
    assign StoreValid = memWrite && !RST;
    assign StoreAddr  = aluY;
    assign StoreData  = rd2Data;

endmodule

/* bench/SingleCpuTb.sv */
`timescale 1ns/10ps

module SingleCpuTb import CpuPkg::*; ();

    localparam int Period  = 40;
    localparam int Seed    = 71099;
    localparam int SeedLen = 31;          // addi x1..x31 prologue
    localparam int LenReset = 40;
    localparam int LenAlu   = SeedLen + 40;
    localparam int LenMem   = SeedLen + 41; // Opening sw, then 20 sw/lw pairs
    localparam int LenMix   = SeedLen + 150;
    // Boot load, reset tail and program per test
    localparam int TotalCycles = 5 * (ImemWords + 4) + LenReset + 2 * LenAlu + LenMem + LenMix;

    logic              CLK;
    logic              RST;
    logic              ProgWe;
    logic [ImemAw-1:0] ProgAddr;
    logic [Xlen-1:0]   ProgData;
    logic [Xlen-1:0]   Pc;
    logic [Xlen-1:0]   Inst;
    logic              WbValid;
    logic [4:0]        WbReg;
    logic [Xlen-1:0]   WbData;
    logic              StoreValid;
    logic [Xlen-1:0]   StoreAddr;
    logic [Xlen-1:0]   StoreData;

    logic [Xlen-1:0] prog[$];
    logic [11:0]     storedAddrs[$]; // Addresses written by sw so far
    logic [Xlen-1:0] modelRegs [32];
    logic [Xlen-1:0] modelMem [logic [Xlen-1:0]];
    int              errorCount;
    int              passCount;
    int              failCount;

    SingleCpu SingleCpu_inst (
        .CLK        (CLK),
        .RST        (RST),
        .ProgWe     (ProgWe),
        .ProgAddr   (ProgAddr),
        .ProgData   (ProgData),
        .Pc         (Pc),
        .Inst       (Inst),
        .WbValid    (WbValid),
        .WbReg      (WbReg),
        .WbData     (WbData),
        .StoreValid (StoreValid),
        .StoreAddr  (StoreAddr),
        .StoreData  (StoreData)
    );

    initial begin
        CLK = 1'b0;
        forever #(Period / 2) CLK = ~CLK;
    end

    initial begin
        #(2 * TotalCycles * Period);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("TEST FAIL");
        $finish;
    end

    // RV32I arithmetic rule selected by funct3
    function automatic logic [Xlen-1:0] aluRule(input logic [2:0] f3, input logic isSub,
                                                input logic isSra, input logic [Xlen-1:0] a,
                                                input logic [Xlen-1:0] b);
        logic [Xlen-1:0] r;
        case (f3)
            3'd0: r = isSub ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (isSra) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Random R-type or I-type word with legal funct7 and shift fields
    function automatic logic [Xlen-1:0] randomAluWord(input logic isReg, input logic [4:0] rs1,
                                                      input logic [4:0] rd);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [6:0]  f7;
        f3  = 3'($urandom);
        alt = 1'($urandom);
        imm = 12'($urandom);
        if (isReg) begin
            f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
            return {f7, 5'($urandom), rs1, f3, rd, OpReg};
        end
        if (f3 == 3'd1) begin
            imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 5'b0, imm[4:0]}; // srai when alt
        end
        return {imm, rs1, f3, rd, OpImm};
    endfunction

    task automatic addStore(input logic [4:0] rs2);
        logic [11:0] addr;
        addr = 12'($urandom_range(0, 255) * 4);
        storedAddrs.push_back(addr);
        prog.push_back({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], OpStore});
    endtask

    task automatic addLoad(input logic [4:0] rd);
        logic [11:0] addr;
        addr = storedAddrs[$urandom_range(0, storedAddrs.size() - 1)];
        prog.push_back({addr, 5'd0, 3'b010, rd, OpLoad});
    endtask

    // Fresh program with every register seeded by addi
    task automatic startSeededProgram();
        prog.delete();
        storedAddrs.delete();
        for (int n = 1; n < 32; n++) begin
            prog.push_back({12'($urandom), 5'd0, 3'b000, 5'(n), OpImm});
        end
    endtask

    task automatic checkValue(input string name, input logic [Xlen-1:0] got,
                              input logic [Xlen-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    // Compare the DUT against the model for instruction i, then retire it
    task automatic stepAndCheck(input int i);
        logic [Xlen-1:0] word;
        logic [Xlen-1:0] a;
        logic [Xlen-1:0] b;
        logic [Xlen-1:0] immI;
        logic [Xlen-1:0] immS;
        logic [Xlen-1:0] result;
        logic [Xlen-1:0] addr;
        logic [4:0]      rd;
        logic            writes;
        logic            stores;
        word   = prog[i];
        rd     = word[11:7];
        a      = modelRegs[word[19:15]];
        b      = modelRegs[word[24:20]];
        immI   = {{20{word[31]}}, word[31:20]};
        immS   = {{20{word[31]}}, word[31:25], word[11:7]};
        writes = 1'b0;
        stores = 1'b0;
        result = '0;
        addr   = '0;
        case (word[6:0])
            OpReg: begin
                result = aluRule(word[14:12], word[30], word[30], a, b);
                writes = 1'b1;
            end
            OpImm: begin
                result = aluRule(word[14:12], 1'b0, word[30], a, immI);
                writes = 1'b1;
            end
            OpLoad: begin
                addr = a + immI;
                assert (modelMem.exists(addr)) else begin
                    $display("load at %h reads an address that no store wrote", addr);
                    errorCount++;
                end
                result = modelMem.exists(addr) ? modelMem[addr] : '0;
                writes = 1'b1;
            end
            OpStore: begin
                addr   = a + immS;
                stores = 1'b1;
            end
            default: ;
        endcase
        checkValue("Pc", Pc, 32'(i * 4));
        checkValue("Inst", Inst, word);
        checkValue("WbValid", WbValid, writes && rd != 5'd0);
        if (writes && rd != 5'd0) begin
            checkValue("WbReg", WbReg, rd);
            checkValue("WbData", WbData, result);
            modelRegs[rd] = result;
        end
        checkValue("StoreValid", StoreValid, stores);
        if (stores) begin
            checkValue("StoreAddr", StoreAddr, addr);
            checkValue("StoreData", StoreData, b);
            modelMem[addr] = b;
        end
    endtask

    task automatic runTest(input string name);
        int errStart;
        errStart = errorCount;
        @(negedge CLK);
        RST = 1'b1;
        for (int a = 0; a < ImemWords; a++) begin
            ProgWe   = 1'b1;
            ProgAddr = ImemAw'(a);
            ProgData = (a < prog.size()) ? prog[a] : NopInst; // Pad with no-ops
            @(negedge CLK);
        end
        ProgWe = 1'b0;
        #(Period / 4);
        // First instruction is fetched but must not retire while in reset
        checkValue("Pc", Pc, 32'd0);
        checkValue("WbValid", WbValid, 1'b0);
        checkValue("StoreValid", StoreValid, 1'b0);
        repeat (3) @(negedge CLK);
        RST = 1'b0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        modelMem.delete();
        for (int i = 0; i < prog.size(); i++) begin
            #(Period / 4); // Settled well before the next rising edge
            stepAndCheck(i);
            @(negedge CLK);
        end
        if (errorCount == errStart) begin
            passCount++;
            $display("%s: passed", name);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", name, errorCount - errStart);
        end
    endtask

    initial begin
        int         kind;
        logic [4:0] rs1;
        logic [4:0] rd;
        logic [4:0] lastRd;
        void'($urandom(Seed));
        RST        = 1'b1;
        ProgWe     = 1'b0;
        ProgAddr   = '0;
        ProgData   = '0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;

        prog.delete();
        for (int n = 0; n < 32; n++) begin
            prog.push_back({7'b0, 5'd0, 5'(n), 3'b000, 5'(n), OpReg}); // add xN, xN, x0
        end
        repeat (4) prog.push_back({12'($urandom), 5'd0, 3'b000, 5'd0, OpImm}); // Into x0
        for (int k = 1; k <= 4; k++) begin
            prog.push_back({7'b0, 5'd0, 5'd0, 3'b000, 5'(k), OpReg});
        end
        runTest("reset and x0");

        startSeededProgram();
        repeat (40) prog.push_back(randomAluWord(1'b1, 5'($urandom), 5'($urandom)));
        runTest("r-type");

        startSeededProgram();
        repeat (40) prog.push_back(randomAluWord(1'b0, 5'($urandom), 5'($urandom)));
        runTest("i-type");

        startSeededProgram();
        addStore(5'd0);
        prog.push_front(prog.pop_back()); // Store of x0 sits at Pc 0 during reset
        repeat (20) begin
            addStore(5'($urandom));
            addLoad(5'($urandom));
        end
        runTest("memory");

        startSeededProgram();
        lastRd = 5'd1;
        for (int k = 0; k < LenMix - SeedLen; k++) begin
            kind = $urandom_range(0, 99);
            rs1  = $urandom_range(0, 1) ? lastRd : 5'($urandom); // Often back to back
            rd   = 5'($urandom);
            if (kind < 40) begin
                prog.push_back(randomAluWord(1'b1, rs1, rd));
            end else if (kind < 75) begin
                prog.push_back(randomAluWord(1'b0, rs1, rd));
            end else if (kind < 88 || storedAddrs.size() == 0) begin
                addStore(lastRd);
            end else begin
                addLoad(rd);
            end
            lastRd = rd;
        end
        runTest("mixed");

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/CpuPkg.sv
hdl/InstMem.sv
hdl/RegFile.sv
hdl/DataMem.sv
hdl/Alu.sv
hdl/Decoder.sv
hdl/SingleCpu.sv
bench/SingleCpuTb.sv

/* Bender.yml */
package:
  name: single_cpu

sources:
  - files:
      - hdl/CpuPkg.sv
      - hdl/InstMem.sv
      - hdl/RegFile.sv
      - hdl/DataMem.sv
      - hdl/Alu.sv
      - hdl/Decoder.sv
      - hdl/SingleCpu.sv
  - target: test
    files:
      - bench/SingleCpuTb.sv
